//--- files.f
hw/core_pkg.sv
hw/pipe_stage_reg.sv
hw/inst_decode.sv
hw/regfile.sv
hw/exec_alu.sv
hw/hold_ctrl.sv
hw/core_top.sv
testbench/core_sva.sv
testbench/tb_core.sv

//--- Makefile
TOOL       := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := tb_core
FLIST      := files.f
LOG        := sim.log
FAIL_MSG   := Done: errors found
PASS_MSG   := Done: no errors
BIN        := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o V$(TOP)

run: build
	./$(BIN) | tee $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_core.sv
// testbench for core_top, fetch model driving a program table and checking every write-back
`timescale 1ns/1ps

module tb_core import core_pkg::*;;

    // one program row, the expected write rides along with its instruction
    typedef struct packed {
        word_t     inst;
        reg_addr_t rd;
        word_t     value;
    } prog_row_t;

    logic      clk;
    logic      reset_i;
    logic      stall_req_i;
    word_t     inst_i;
    word_t     inst_addr_i;
    logic      wb_we_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;
    logic      jump_o;
    word_t     jump_addr_o;
    hold_t     hold_flag_o;

    prog_row_t   prog[$];  // indexed by word address
    prog_row_t   exp_q[$]; // writes in program order
    int          errors;
    int          exp_idx;  // next expected write
    int          cycles;   // edges since reset release
    int          limit;
    int          drain;    // edges spent past the last row
    word_t       pc;       // address currently presented
    logic        done;

    core_top core_top_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_req_i (stall_req_i),
        .inst_i      (inst_i),
        .inst_addr_i (inst_addr_i),
        .wb_we_o     (wb_we_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o),
        .jump_o      (jump_o),
        .jump_addr_o (jump_addr_o),
        .hold_flag_o (hold_flag_o)
    );

    always #4 clk = ~clk; // 8 ns period

    // rv32i encoders, operands given as plain numbers
    function automatic word_t enc_i(input logic [31:0] imm, rs1, input logic [2:0] f3,
                                    input logic [31:0] rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input logic [31:0] rs2, rs1,
                                    input logic [2:0] f3, input logic [31:0] rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic word_t enc_u(input logic [31:0] imm20, rd, input logic [6:0] opc);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic word_t enc_j(input logic [31:0] off, rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic word_t enc_b(input logic [31:0] off, rs2, rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    task automatic add_write(input word_t inst, input logic [31:0] rd, input word_t value);
        prog_row_t row;
        row = '{inst: inst, rd: rd[4:0], value: value};
        prog.push_back(row);
        exp_q.push_back(row);
    endtask

    task automatic add_silent(input word_t inst);
        prog_row_t row;
        row = '{inst: inst, rd: 5'd0, value: 32'h0};
        prog.push_back(row); // skipped, branch, x0 or unknown
    endtask

    // expected values worked out by hand, address = 4 * row index
    task automatic load_program();
        add_write(enc_i(5, 0, 3'b000, 1, OPC_OP_IMM), 1, 32'h5);             // addi
        add_write(enc_i(-3, 0, 3'b000, 2, OPC_OP_IMM), 2, 32'hffff_fffd);    // addi negative
        add_write(enc_r(7'h00, 2, 1, 3'b000, 3), 3, 32'h2);                  // add, back to back
        add_write(enc_r(7'h20, 1, 2, 3'b000, 4), 4, 32'hffff_fff8);          // sub
        add_write(enc_r(7'h00, 1, 2, 3'b010, 5), 5, 32'h1);                  // slt -3 < 5
        add_write(enc_r(7'h00, 1, 2, 3'b011, 6), 6, 32'h0);                  // sltu, -3 is huge
        add_write(enc_i(-2, 2, 3'b010, 7, OPC_OP_IMM), 7, 32'h1);            // slti
        add_write(enc_i(32'hf, 1, 3'b100, 8, OPC_OP_IMM), 8, 32'ha);         // xori
        add_write(enc_i(32'h30, 1, 3'b110, 9, OPC_OP_IMM), 9, 32'h35);       // ori
        add_write(enc_i(32'hf0, 2, 3'b111, 10, OPC_OP_IMM), 10, 32'hf0);     // andi
        add_write(enc_i(4, 1, 3'b001, 11, OPC_OP_IMM), 11, 32'h50);          // slli
        add_write(enc_i(28, 4, 3'b101, 12, OPC_OP_IMM), 12, 32'hf);          // srli
        add_write(enc_i(32'h402, 4, 3'b101, 13, OPC_OP_IMM), 13, 32'hffff_fffe); // srai
        add_write(enc_r(7'h00, 1, 1, 3'b001, 14), 14, 32'ha0);               // sll
        add_write(enc_r(7'h00, 1, 4, 3'b101, 15), 15, 32'h07ff_ffff);        // srl
        add_write(enc_r(7'h20, 1, 4, 3'b101, 16), 16, 32'hffff_ffff);        // sra
        add_write(enc_r(7'h00, 2, 1, 3'b100, 17), 17, 32'hffff_fff8);        // xor
        add_write(enc_r(7'h00, 2, 1, 3'b110, 18), 18, 32'hffff_fffd);        // or
        add_write(enc_r(7'h00, 2, 1, 3'b111, 19), 19, 32'h5);                // and
        add_write(enc_u(32'h12345, 20, OPC_LUI), 20, 32'h1234_5000);         // lui
        add_write(enc_u(32'h1, 21, OPC_AUIPC), 21, 32'h1050);                // auipc at 0x50
        add_write(enc_j(12, 22), 22, 32'h58);                                // jal 0x54 to 0x60
        add_silent(enc_i(99, 0, 3'b000, 23, OPC_OP_IMM));                    // wrong path
        add_silent(enc_i(98, 0, 3'b000, 23, OPC_OP_IMM));                    // wrong path
        add_silent(enc_i(7, 0, 3'b000, 0, OPC_OP_IMM));                      // write to x0
        add_silent(32'hffff_ffff);                                           // unknown opcode
        add_write(enc_r(7'h00, 1, 0, 3'b000, 24), 24, 32'h5);                // x0 reads zero
        add_silent(enc_b(12, 1, 1, 3'b000));                                 // beq taken to 0x78
        add_silent(enc_i(1, 0, 3'b000, 25, OPC_OP_IMM));
        add_silent(enc_i(2, 0, 3'b000, 25, OPC_OP_IMM));
        add_silent(enc_b(8, 1, 1, 3'b001));                                  // bne not taken
        add_write(enc_i(3, 0, 3'b000, 25, OPC_OP_IMM), 25, 32'h3);
        add_silent(enc_b(12, 2, 1, 3'b001));                                 // bne taken to 0x8c
        add_silent(enc_i(1, 0, 3'b000, 26, OPC_OP_IMM));
        add_silent(enc_i(2, 0, 3'b000, 26, OPC_OP_IMM));
        add_silent(enc_b(12, 1, 2, 3'b100));                                 // blt taken to 0x98
        add_silent(enc_i(1, 0, 3'b000, 27, OPC_OP_IMM));
        add_silent(enc_i(2, 0, 3'b000, 27, OPC_OP_IMM));
        add_silent(enc_b(8, 2, 1, 3'b100));                                  // blt not taken
        add_write(enc_i(4, 0, 3'b000, 27, OPC_OP_IMM), 27, 32'h4);
        add_silent(enc_b(12, 2, 1, 3'b101));                                 // bge taken to 0xac
        add_silent(enc_i(1, 0, 3'b000, 28, OPC_OP_IMM));
        add_silent(enc_i(2, 0, 3'b000, 28, OPC_OP_IMM));
        add_silent(enc_b(8, 1, 2, 3'b101));                                  // bge not taken
        add_write(enc_i(6, 0, 3'b000, 28, OPC_OP_IMM), 28, 32'h6);
        add_write(enc_i(32'hc2, 0, 3'b000, 30, OPC_OP_IMM), 30, 32'hc2);
        add_write(enc_i(3, 30, 3'b000, 29, OPC_JALR), 29, 32'hbc);           // 0xc5 to 0xc4
        add_silent(enc_i(1, 0, 3'b000, 31, OPC_OP_IMM));
        add_silent(enc_i(2, 0, 3'b000, 31, OPC_OP_IMM));
        add_write(enc_i(-1, 0, 3'b000, 31, OPC_OP_IMM), 31, 32'hffff_ffff);
        add_write(enc_r(7'h00, 31, 0, 3'b011, 26), 26, 32'h1);               // sltu x0 < -1
    endtask

    // past the table or off a word boundary the fetch side feeds nops
    function automatic word_t fetch_word(input word_t addr);
        if (addr[1:0] == 2'b00 && addr[31:2] < prog.size()) return prog[addr[31:2]].inst;
        return INST_NOP;
    endfunction

    task automatic check_idle();
        assert (!wb_we_o && !jump_o) else begin
            errors++;
            $display("write-back or jump active at %0t before any instruction executed", $time);
        end
    endtask

    task automatic check_writeback();
        prog_row_t e;
        if (wb_we_o) begin
            assert (exp_idx < exp_q.size()) else begin
                errors++;
                $display("unexpected extra write to x%0d at %0t", wb_addr_o, $time);
            end
            if (exp_idx < exp_q.size()) begin
                e = exp_q[exp_idx];
                assert (wb_addr_o == e.rd) else begin
                    errors++;
                    $display("mismatch at %0t: wb_addr_o got %0d expected %0d",
                             $time, wb_addr_o, e.rd);
                end
                assert (wb_data_o == e.value) else begin
                    errors++;
                    $display("mismatch at %0t: wb_data_o got %h expected %h",
                             $time, wb_data_o, e.value);
                end
                exp_idx++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h3fd2)); // seeds the generator for the run
        clk         = 1'b0;
        reset_i     = 1'b1;
        stall_req_i = 1'b0;
        inst_i      = INST_NOP;
        inst_addr_i = 32'h0;
        errors      = 0;
        exp_idx     = 0;
        cycles      = 0;
        drain       = 0;
        pc          = 32'h0;
        done        = 1'b0;
        load_program();
        limit = 4 * prog.size() + 40;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) check_idle(); // bubbles loaded from the first edge on
        end
        reset_i     <= 1'b0;
        inst_i      <= fetch_word(pc);
        inst_addr_i <= pc;
        while (!done) begin
            @(posedge clk);
            cycles++;
            check_writeback();       // outputs settled since the last edge
            if (cycles <= 2) check_idle();
            if (jump_o) begin
                pc = jump_addr_o;    // presented word flushed
            end else if (hold_flag_o < HOLD_PC) begin
                pc = pc + 32'd4;     // presented word captured
            end
            stall_req_i <= ($urandom_range(3) == 0); // about one cycle in four
            inst_i      <= fetch_word(pc);
            inst_addr_i <= pc;
            if (pc >= 4 * prog.size()) drain++;
            if (drain >= 6) done = 1'b1; // last row has left execute
            assert (cycles < limit) else begin
                errors++;
                $display("timeout, program did not finish within %0d cycles", limit);
                done = 1'b1;
            end
        end
        assert (exp_idx == exp_q.size()) else begin
            errors++;
            $display("missing writes, saw %0d of %0d expected", exp_idx, exp_q.size());
        end
        $display("errors: %0d, writes checked: %0d, cycles: %0d", errors, exp_idx, cycles);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- testbench/core_sva.sv
// bound assertions on the core ports, jump flush, post-jump bubble and write-back address
`timescale 1ns/1ps

module core_sva import core_pkg::*; (
    input logic      clk,
    input logic      reset_i,
    input logic      wb_we_o,
    input reg_addr_t wb_addr_o,
    input logic      jump_o,
    input hold_t     hold_flag_o
);

    // a jump must squash both younger stages
    a_jump_flush: assert property (@(posedge clk) disable iff (reset_i)
        jump_o |-> (hold_flag_o == HOLD_ID))
        else $error("jump without HOLD_ID hold level");

    // cycle after a jump executes a bubble
    a_jump_bubble: assert property (@(posedge clk) disable iff (reset_i)
        jump_o |=> (!wb_we_o && !jump_o))
        else $error("write-back or jump in the cycle after a jump");

    // x0 writes are dropped in decode
    a_wb_nonzero: assert property (@(posedge clk) disable iff (reset_i)
        wb_we_o |-> (wb_addr_o != 5'd0))
        else $error("write-back enabled towards x0");

endmodule

bind core_top core_sva core_sva_inst (
    .clk         (clk),
    .reset_i     (reset_i),
    .wb_we_o     (wb_we_o),
    .wb_addr_o   (wb_addr_o),
    .jump_o      (jump_o),
    .hold_flag_o (hold_flag_o)
);

//--- hw/core_top.sv
// core top, if/id and id/ex registers, decoder, register file, execute and hold control
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  stall_req_i, // fetch stall request
    input  word_t inst_i,      // instruction from fetch
    input  word_t inst_addr_i, // its address
    output logic  wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t wb_data_o,
    output logic  jump_o,      // redirect fetch
    output word_t jump_addr_o,
    output hold_t hold_flag_o  // fetch keeps pc at HOLD_PC and above
);

    if_id_t if_id_d;
    if_id_t if_id_q;
    id_ex_t id_ex_d;
    id_ex_t id_ex_q;
    word_t  rdata1;
    word_t  rdata2;
    wb_t    wb;
    logic   jump;
    hold_t  hold_flag;

    assign if_id_d = '{inst: inst_i, inst_addr: inst_addr_i};

    pipe_stage_reg #(
        .payload_t  (if_id_t),
        .BUBBLE     (IF_ID_BUBBLE),
        .HOLD_LEVEL (HOLD_IF)       // squashed by stalls and jumps
    ) if_id_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .hold_flag_i (hold_flag),
        .data_i      (if_id_d),
        .data_o      (if_id_q)
    );

    inst_decode inst_decode_inst (
        .if_id_i (if_id_q),
        .id_ex_o (id_ex_d)
    );

    pipe_stage_reg #(
        .payload_t  (id_ex_t),
        .BUBBLE     (ID_EX_BUBBLE),
        .HOLD_LEVEL (HOLD_ID)       // squashed by jumps only
    ) id_ex_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .hold_flag_i (hold_flag),
        .data_i      (id_ex_d),
        .data_o      (id_ex_q)
    );

    // read addresses come from id/ex, reads happen in execute
    regfile regfile_inst (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (id_ex_q.reg1_raddr),
        .raddr2_i (id_ex_q.reg2_raddr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wb_i     (wb)
    );

    exec_alu exec_alu_inst (
        .id_ex_i     (id_ex_q),
        .rdata1_i    (rdata1),
        .rdata2_i    (rdata2),
        .wb_o        (wb),
        .jump_o      (jump),
        .jump_addr_o (jump_addr_o)
    );

    hold_ctrl hold_ctrl_inst (
        .stall_req_i (stall_req_i),
        .jump_i      (jump),
        .hold_flag_o (hold_flag)
    );

    assign wb_we_o     = wb.we;
    assign wb_addr_o   = wb.addr;
    assign wb_data_o   = wb.data;
    assign jump_o      = jump;
    assign hold_flag_o = hold_flag;

endmodule

//--- hw/hold_ctrl.sv
// hold controller, ranks the jump flush and the fetch stall into one hold level
`timescale 1ns/1ps

module hold_ctrl import core_pkg::*; (
    input  logic  stall_req_i, // fetch side not ready, level
    input  logic  jump_i,      // taken jump from execute, pulse
    output hold_t hold_flag_o  // to both stage registers and fetch
);

    always_comb begin
        if (jump_i) begin
            hold_flag_o = HOLD_ID;   // flush wins, both younger stages squashed
        end else if (stall_req_i) begin
            hold_flag_o = HOLD_IF;   // keep pc, bubble into if/id only
        end else begin
            hold_flag_o = HOLD_NONE;
        end
    end

endmodule

//--- hw/exec_alu.sv
// execute stage, alu, branch compare and jump target, drives write-back and jump request
`timescale 1ns/1ps

module exec_alu import core_pkg::*; (
    input  id_ex_t id_ex_i,     // payload from id/ex
    input  word_t  rdata1_i,    // rs1 value
    input  word_t  rdata2_i,    // rs2 value
    output wb_t    wb_o,        // register write-back
    output logic   jump_o,      // redirect fetch, flush younger stages
    output word_t  jump_addr_o  // redirect target
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      add_res;   // shared by add, addi and jalr
    word_t      pc_imm;    // inst_addr + imm, for auipc, jal and branches
    word_t      link;      // return address
    word_t      result;
    logic       lt_s;      // signed compare of rs1 and operand b
    logic       lt_u;
    logic       br_eq;     // branch compares always use rs2
    logic       br_lt;

    assign op_a    = rdata1_i;
    assign op_b    = id_ex_i.dec_info.use_imm ? id_ex_i.imm : rdata2_i;
    assign shamt   = op_b[4:0]; // low 5 bits only, srai funct7 bit ignored
    assign add_res = op_a + op_b;
    assign pc_imm  = id_ex_i.inst_addr + id_ex_i.imm;
    assign link    = id_ex_i.inst_addr + 32'd4;
    assign lt_s    = $signed(op_a) < $signed(op_b);
    assign lt_u    = op_a < op_b;
    assign br_eq   = (rdata1_i == rdata2_i);
    assign br_lt   = $signed(rdata1_i) < $signed(rdata2_i);

    always_comb begin
        result      = 32'h0;
        jump_o      = 1'b0;
        jump_addr_o = 32'h0;
        case (id_ex_i.dec_info.op)
            OP_ADD:   result = add_res;
            OP_SUB:   result = op_a - op_b;
            OP_SLT:   result = {31'b0, lt_s};
            OP_SLTU:  result = {31'b0, lt_u};
            OP_XOR:   result = op_a ^ op_b;
            OP_OR:    result = op_a | op_b;
            OP_AND:   result = op_a & op_b;
            OP_SLL:   result = op_a << shamt;
            OP_SRL:   result = op_a >> shamt;
            OP_SRA:   result = $unsigned($signed(op_a) >>> shamt); // sign fill
            OP_LUI:   result = id_ex_i.imm;
            OP_AUIPC: result = pc_imm;
            OP_JAL: begin
                result      = link;
                jump_o      = 1'b1;
                jump_addr_o = pc_imm;
            end
            OP_JALR: begin
                result      = link;
                jump_o      = 1'b1;
                jump_addr_o = {add_res[31:1], 1'b0}; // bit 0 cleared
            end
            OP_BEQ: begin
                jump_o      = br_eq;
                jump_addr_o = pc_imm;
            end
            OP_BNE: begin
                jump_o      = !br_eq;
                jump_addr_o = pc_imm;
            end
            OP_BLT: begin
                jump_o      = br_lt;
                jump_addr_o = pc_imm;
            end
            OP_BGE: begin
                jump_o      = !br_lt;
                jump_addr_o = pc_imm;
            end
            default: begin
                result = 32'h0;  // nop and bubbles
            end
        endcase
    end

    // decode already cleared reg_we for x0, branches and nops
    assign wb_o.we   = id_ex_i.reg_we;
    assign wb_o.addr = id_ex_i.reg_waddr;
    assign wb_o.data = result;

endmodule

//--- hw/regfile.sv
// general register file, 32 x 32 bits, two combinational reads and one write, x0 reads zero
`timescale 1ns/1ps

module regfile import core_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t raddr1_i, // rs1 address
    input  reg_addr_t raddr2_i, // rs2 address
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  wb_t       wb_i      // write port from execute
);

    word_t regs [1:31]; // no storage for x0

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (wb_i.we && (wb_i.addr != 5'd0)) begin
            regs[wb_i.addr] <= wb_i.data; // x0 writes ignored
        end
    end

    // read sees the value written at the previous edge, no bypass needed
    assign rdata1_o = (raddr1_i == 5'd0) ? 32'h0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? 32'h0 : regs[raddr2_i];

endmodule

//--- hw/inst_decode.sv
// instruction decoder, rv32i subset into register addresses, immediate and decode info
`timescale 1ns/1ps

module inst_decode import core_pkg::*; (
    input  if_id_t if_id_i, // fetched instruction and address
    output id_ex_t id_ex_o  // decoded payload for id/ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_b;

    exec_op_t   op;
    logic       use_imm;
    logic       writes;      // instruction class writes rd
    logic       uses_rs1;
    logic       uses_rs2;
    word_t      imm;

    assign opcode = if_id_i.inst[6:0];
    assign rd     = if_id_i.inst[11:7];
    assign funct3 = if_id_i.inst[14:12];
    assign rs1    = if_id_i.inst[19:15];
    assign rs2    = if_id_i.inst[24:20];
    assign funct7 = if_id_i.inst[31:25];

    // immediate formats, all sign extended from bit 31
    assign imm_i = {{20{if_id_i.inst[31]}}, if_id_i.inst[31:20]};
    assign imm_u = {if_id_i.inst[31:12], 12'b0};
    assign imm_j = {{12{if_id_i.inst[31]}}, if_id_i.inst[19:12], if_id_i.inst[20],
                    if_id_i.inst[30:21], 1'b0};
    assign imm_b = {{20{if_id_i.inst[31]}}, if_id_i.inst[7], if_id_i.inst[30:25],
                    if_id_i.inst[11:8], 1'b0};

    always_comb begin
        op       = OP_NOP;  // unknown encodings fall through as nop
        use_imm  = 1'b0;
        writes   = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        imm      = 32'h0;
        case (opcode)
            OPC_LUI: begin
                op = OP_LUI; use_imm = 1'b1; writes = 1'b1; imm = imm_u;
            end
            OPC_AUIPC: begin
                op = OP_AUIPC; use_imm = 1'b1; writes = 1'b1; imm = imm_u;
            end
            OPC_JAL: begin
                op = OP_JAL; use_imm = 1'b1; writes = 1'b1; imm = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    op = OP_JALR; use_imm = 1'b1; writes = 1'b1; uses_rs1 = 1'b1;
                    imm = imm_i;  // target is rs1 + imm
                end
            end
            OPC_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm      = imm_b;
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    default: op = OP_NOP; // unsigned branches not kept
                endcase
            end
            OPC_OP_IMM: begin
                use_imm  = 1'b1;
                uses_rs1 = 1'b1;
                imm      = imm_i;
                case (funct3)
                    3'b000: op = OP_ADD;
                    3'b010: op = OP_SLT;
                    3'b100: op = OP_XOR;
                    3'b110: op = OP_OR;
                    3'b111: op = OP_AND;
                    3'b001: op = (funct7 == 7'b0000000) ? OP_SLL : OP_NOP;
                    3'b101: begin
                        if (funct7 == 7'b0000000)      op = OP_SRL;
                        else if (funct7 == 7'b0100000) op = OP_SRA;
                    end
                    default: op = OP_NOP; // sltiu not kept
                endcase
                writes = (op != OP_NOP);
            end
            OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op = OP_ADD;
                    {7'b0100000, 3'b000}: op = OP_SUB;
                    {7'b0000000, 3'b001}: op = OP_SLL;
                    {7'b0000000, 3'b010}: op = OP_SLT;
                    {7'b0000000, 3'b011}: op = OP_SLTU;
                    {7'b0000000, 3'b100}: op = OP_XOR;
                    {7'b0000000, 3'b101}: op = OP_SRL;
                    {7'b0100000, 3'b101}: op = OP_SRA;
                    {7'b0000000, 3'b110}: op = OP_OR;
                    {7'b0000000, 3'b111}: op = OP_AND;
                    default:              op = OP_NOP;
                endcase
                writes = (op != OP_NOP);
            end
            default: op = OP_NOP;
        endcase
    end

    assign id_ex_o.inst_addr        = if_id_i.inst_addr;
    assign id_ex_o.reg_we           = writes && (rd != 5'd0); // x0 writes dropped here
    assign id_ex_o.reg_waddr        = writes ? rd : 5'd0;
    assign id_ex_o.reg1_raddr       = uses_rs1 ? rs1 : 5'd0;
    assign id_ex_o.reg2_raddr       = uses_rs2 ? rs2 : 5'd0;
    assign id_ex_o.dec_info.op      = op;
    assign id_ex_o.dec_info.use_imm = use_imm;
    assign id_ex_o.imm              = imm;

endmodule

//--- hw/pipe_stage_reg.sv
// pipeline stage register, loads its bubble when the hold level reaches its own level
`timescale 1ns/1ps

module pipe_stage_reg import core_pkg::*; #(
    parameter type      payload_t  = logic [31:0],
    parameter payload_t BUBBLE     = '0,
    parameter hold_t    HOLD_LEVEL = HOLD_ID
) (
    input  logic     clk,
    input  logic     reset_i,
    input  hold_t    hold_flag_i, // current hold level
    input  payload_t data_i,      // payload from the stage before
    output payload_t data_o       // registered payload
);

    logic hold_en;

    assign hold_en = (hold_flag_i >= HOLD_LEVEL); // ordered compare on the enum

    always_ff @(posedge clk) begin
        if (reset_i) begin
            data_o <= BUBBLE;  // empty pipe after reset
        end else if (hold_en) begin
            data_o <= BUBBLE;  // squash, the stage ahead re-presents or is flushed
        end else begin
            data_o <= data_i;
        end
    end

endmodule

//--- hw/core_pkg.sv
// core package with pipeline payload types, hold levels, opcodes and bubble constants
package core_pkg;

    typedef logic [31:0] word_t;     // data and address word
    typedef logic [4:0]  reg_addr_t; // general register index

    // ordered, a stage squashes at or above its own level
    typedef enum logic [1:0] {
        HOLD_NONE = 2'd0, // free running
        HOLD_PC   = 2'd1, // fetch keeps its pc
        HOLD_IF   = 2'd2, // if/id loads a bubble
        HOLD_ID   = 2'd3  // id/ex loads a bubble too
    } hold_t;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
        OP_XOR, OP_OR, OP_AND,
        OP_SLL, OP_SRL, OP_SRA,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
        OP_NOP
    } exec_op_t;

    typedef struct packed {
        exec_op_t op;      // execute operation
        logic     use_imm; // operand b from imm, not rs2
    } dec_info_t;

    typedef struct packed {
        word_t inst;      // raw instruction
        word_t inst_addr; // its fetch address
    } if_id_t;

    // register addresses travel, data is read in execute
    typedef struct packed {
        word_t     inst_addr;
        logic      reg_we;     // writes rd
        reg_addr_t reg_waddr;  // rd
        reg_addr_t reg1_raddr; // rs1
        reg_addr_t reg2_raddr; // rs2
        dec_info_t dec_info;
        word_t     imm;        // sign extended immediate
    } id_ex_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    // base opcodes of the kept subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam word_t INST_NOP = 32'h0000_0013; // addi x0, x0, 0

    localparam if_id_t IF_ID_BUBBLE = '{
        inst:      INST_NOP,
        inst_addr: 32'h0
    };

    // zero payload, but the op field must still say nop
    localparam id_ex_t ID_EX_BUBBLE = '{
        inst_addr:  32'h0,
        reg_we:     1'b0,
        reg_waddr:  5'd0,
        reg1_raddr: 5'd0,
        reg2_raddr: 5'd0,
        dec_info:   '{op: OP_NOP, use_imm: 1'b0},
        imm:        32'h0
    };

endpackage
